// File: Makefile
VERILATOR ?= verilator
TOP ?= excUnitTb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: list.f
verilog/cp0Pkg.sv
verilog/excEncoder.sv
verilog/cp0Regs.sv
verilog/irqTimer.sv
verilog/excUnit.sv
tb/clockGen.sv
tb/excUnitTb.sv

// File: tb/clockGen.sv
`timescale 1ns/100ps

module clockGen (
	output logic clk,
	output logic reset
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Reset held for five rising edges, released just after the fifth
	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
	end

endmodule

// File: tb/excCases.txt
# W addr data | R addr exp | X flags pc bd req | I ext | E | T addr data | Q addr exp | P bound
# All hex. Flags bits 5..0 are fetchAdEL ri sys ov loadAdEL storeAdES
R 0f 00018200
R 09 00000000
W 0f 12345678
R 0f 12345678
W 0e 00001003
R 0e 00001000
W 0c ffffffff
R 0c 0000fc03
W 0d ffffffff
R 0d 8000007c
W 0c 00000000
R 0c 00000000
X 20 00001002 0 1
R 0d 00000010
R 0c 00000002
R 0e 00001000
E
X 10 00002000 0 1
R 0d 00000028
E
X 08 00002010 0 1
R 0d 00000020
E
X 04 00002020 0 1
R 0d 00000030
E
X 02 00002030 0 1
R 0d 00000010
E
X 01 00002040 0 1
R 0d 00000014
E
X 04 00003002 1 1
R 0e 00002ffc
R 0d 80000030
X 20 00004000 0 0
R 0e 00002ffc
E
R 0d 00000030
X 3f 00005000 0 1
R 0d 00000010
E
X 03 00005020 0 1
R 0d 00000010
E
I 01
X 00 00006000 0 0
R 0d 00000810
W 0c 00001001
X 00 00006000 0 0
W 0c 00000800
X 00 00006000 0 0
W 0c 00000801
X 20 00006008 0 1
X 00 00006100 0 0
R 0d 00000800
R 0e 00006008
R 0c 00000803
E
X 00 00007000 0 1
R 0e 00007000
I 00
W 0c 00000401
T 1 00000005
T 0 00000009
Q 2 00000005
Q 0 00000009
P 07
R 0d 00000400
Q 2 00000000
R 0c 00000403
T 0 0000000b
E
Q 2 00000004
P 07
R 0d 00000400
Q 2 00000004
R 0c 00000403

// File: tb/excUnitTb.sv
`timescale 1ns/100ps

module excUnitTb;

	logic clk;
	logic reset;

	// DUT inputs
	cp0Pkg::cp0Access_t cp0Bus;
	cp0Pkg::timerAccess_t timerBus;
	cp0Pkg::excFlags_t flags;
	logic [31:0] pc;
	logic bdIn;
	logic exlClr;
	logic [4:0] extInt;

	// DUT outputs
	logic [31:0] cp0RdData;
	logic [31:0] timerRdData;
	logic excRequest;
	logic [31:0] epc;

	// Reference model of the SR fields
	logic [5:0] mIm;
	logic mExl;
	logic mIe;

	// Case lines and watchdog budget
	string caseLines[$];
	int budgetCycles;
	logic budgetReady;

	clockGen clocks (
		.clk(clk),
		.reset(reset)
	);

	excUnit UUT (
		.clk(clk),
		.reset(reset),
		.cp0Bus(cp0Bus),
		.cp0RdData(cp0RdData),
		.timerBus(timerBus),
		.timerRdData(timerRdData),
		.pc(pc),
		.bdIn(bdIn),
		.flags(flags),
		.exlClr(exlClr),
		.extInt(extInt),
		.excRequest(excRequest),
		.epc(epc)
	);

	//////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////

	task automatic reportFail(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expVal,
		input logic [31:0] gotVal);
		assert (gotVal === expVal)
			else reportFail($sformatf("[FAIL] %s expected %h got %h", name, expVal, gotVal));
	endtask

	// File expectation against the model
	task automatic crossCheck(input string what, input int caseNo,
		input logic [31:0] modelVal, input logic [31:0] fileVal);
		assert (modelVal === fileVal)
			else reportFail($sformatf("Case %0d expects a %s that the reference model disagrees with",
				caseNo, what));
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Timer line left out, polls account for it
	function automatic logic modelRequest();
		logic intReq;
		intReq = (|({extInt, 1'b0} & mIm)) & mIe & ~mExl;
		return intReq | ((|flags) & ~mExl);
	endfunction

	function automatic logic [31:0] modelSrWord();
		logic [31:0] w;
		w = '0;
		w[cp0Pkg::srImHi:cp0Pkg::srImLo] = mIm;
		w[cp0Pkg::srExlBit] = mExl;
		w[cp0Pkg::srIeBit] = mIe;
		return w;
	endfunction

	// Model update for the coming edge, then move to 1 ns past it
	task automatic stepEdge(input logic timerReq);
		logic req;
		req = modelRequest() | timerReq;
		if (cp0Bus.we && cp0Bus.wrAddr == cp0Pkg::regSr) begin
			mIm = cp0Bus.wrData[cp0Pkg::srImHi:cp0Pkg::srImLo];
			mExl = cp0Bus.wrData[cp0Pkg::srExlBit];
			mIe = cp0Bus.wrData[cp0Pkg::srIeBit];
		end
		if (req) begin
			mExl = 1'b1;
		end
		// eret wins
		if (exlClr) begin
			mExl = 1'b0;
		end
		@(posedge clk);
		#1;
	endtask

	//////////////////////////////////////////////////
	// Operations
	//////////////////////////////////////////////////

	task automatic pollRequest(input logic [31:0] bound);
		int waited;
		waited = 0;
		while (waited < int'(bound)) begin
			@(negedge clk);
			if (excRequest) begin
				stepEdge(1'b1);
				return;
			end
			stepEdge(1'b0);
			waited++;
		end
		reportFail($sformatf("excRequest did not rise within %0d cycles", bound));
	endtask

	task automatic runCase(input string line, input int caseNo);
		logic [7:0] op;
		string fields;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		a = '0;
		b = '0;
		c = '0;
		d = '0;
		op = line.getc(0);
		fields = line.substr(1, line.len() - 1);
		void'($sscanf(fields, "%h %h %h %h", a, b, c, d));
		case (op)
			"W": begin
				cp0Bus.we = 1'b1;
				cp0Bus.wrAddr = a[4:0];
				cp0Bus.wrData = b;
				stepEdge(1'b0);
				cp0Bus.we = 1'b0;
			end
			"R": begin
				cp0Bus.rdAddr = a[4:0];
				@(negedge clk);
				if (a[4:0] == cp0Pkg::regSr) begin
					crossCheck("SR value", caseNo, modelSrWord(), b);
				end
				checkValue("cp0RdData", b, cp0RdData);
				// EPC port mirrors the register
				if (a[4:0] == cp0Pkg::regEpc) begin
					checkValue("epc", b, epc);
				end
				stepEdge(1'b0);
			end
			"X": begin
				flags = a[5:0];
				pc = b;
				bdIn = c[0];
				@(negedge clk);
				crossCheck("excRequest level", caseNo, {31'b0, modelRequest()}, d);
				checkValue("excRequest", d, {31'b0, excRequest});
				stepEdge(1'b0);
				flags = '0;
				bdIn = 1'b0;
			end
			// Level only, no clock edge
			"I": extInt = a[4:0];
			"E": begin
				exlClr = 1'b1;
				stepEdge(1'b0);
				exlClr = 1'b0;
			end
			"T": begin
				timerBus.we = 1'b1;
				timerBus.addr = a[1:0];
				timerBus.wrData = b;
				stepEdge(1'b0);
				timerBus.we = 1'b0;
			end
			"Q": begin
				timerBus.addr = a[1:0];
				@(negedge clk);
				checkValue("timerRdData", b, timerRdData);
				stepEdge(1'b0);
			end
			"P": pollRequest(a);
			default: reportFail($sformatf("Case %0d has an unknown operation", caseNo));
		endcase
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		int fd;
		string line;
		logic [31:0] bound;
		cp0Bus = '0;
		timerBus = '0;
		flags = '0;
		pc = '0;
		bdIn = 1'b0;
		exlClr = 1'b0;
		extInt = '0;
		mIm = '0;
		mExl = 1'b0;
		mIe = 1'b0;
		budgetCycles = 0;
		budgetReady = 1'b0;
		bound = '0;

		fd = $fopen("tb/excCases.txt", "r");
		if (fd == 0) begin
			reportFail("Could not open tb/excCases.txt");
		end
		// Skip comments and blank lines
		while ($fgets(line, fd) > 0) begin
			if (line.len() > 1 && line.getc(0) != "#") begin
				caseLines.push_back(line);
				budgetCycles += 20;
				if (line.getc(0) == "P") begin
					void'($sscanf(line.substr(1, line.len() - 1), "%h", bound));
					budgetCycles += int'(bound);
				end
			end
		end
		$fclose(fd);
		budgetReady = 1'b1;

		@(negedge reset);
		foreach (caseLines[i]) begin
			runCase(caseLines[i], i + 1);
		end
		$display("RESULT: PASS");
		$finish;
	end

	// Watchdog
	initial begin
		wait (budgetReady);
		#(budgetCycles * 10);
		reportFail("Watchdog timeout, the case list did not finish in time");
	end

endmodule

// File: verilog/cp0Pkg.sv
package cp0Pkg;

	//////////////////////////////////////////////////
	// CP0 register numbers
	//////////////////////////////////////////////////
	localparam logic [4:0] regSr = 5'd12;
	localparam logic [4:0] regCause = 5'd13;
	localparam logic [4:0] regEpc = 5'd14;
	localparam logic [4:0] regPrid = 5'd15;

	// Processor id after reset
	localparam logic [31:0] prIdReset = 32'h0001_8200;

	// SR field positions
	localparam int srIeBit = 0;
	localparam int srExlBit = 1;
	localparam int srImLo = 10;
	localparam int srImHi = 15;

	// Cause field positions
	localparam int causeCodeLo = 2;
	localparam int causeCodeHi = 6;
	localparam int causeIpLo = 10;
	localparam int causeIpHi = 15;
	localparam int causeBdBit = 31;

	//////////////////////////////////////////////////
	// Exception cause codes
	//////////////////////////////////////////////////
	localparam logic [4:0] codeInt = 5'd0;
	localparam logic [4:0] codeAdEL = 5'd4;
	localparam logic [4:0] codeAdES = 5'd5;
	localparam logic [4:0] codeSys = 5'd8;
	localparam logic [4:0] codeRi = 5'd10;
	localparam logic [4:0] codeOv = 5'd12;

	// Memory stage flags, highest priority first
	typedef struct packed {
		logic fetchAdEL;
		logic ri;
		logic sys;
		logic ov;
		logic loadAdEL;
		logic storeAdES;
	} excFlags_t;

	// mtc0 / mfc0 access
	typedef struct packed {
		logic we;
		logic [4:0] rdAddr;
		logic [4:0] wrAddr;
		logic [31:0] wrData;
	} cp0Access_t;

	//////////////////////////////////////////////////
	// Timer
	//////////////////////////////////////////////////
	localparam logic [1:0] timerAddrCtrl = 2'd0;
	localparam logic [1:0] timerAddrPreset = 2'd1;
	localparam logic [1:0] timerAddrCount = 2'd2;

	// Control register bits
	localparam int timerCtrlEnBit = 0;
	localparam int timerCtrlModeBit = 1;
	localparam int timerCtrlIrqEnBit = 3;

	// Timer line in the hardware interrupt vector
	localparam int hwIntTimer = 0;

	typedef struct packed {
		logic we;
		logic [1:0] addr;
		logic [31:0] wrData;
	} timerAccess_t;

endpackage

// File: verilog/cp0Regs.sv
`timescale 1ns/100ps

module cp0Regs (
	input logic clk,
	input logic reset,
	input cp0Pkg::cp0Access_t cp0Bus,
	input logic [4:0] excCode,
	input logic [5:0] hwInt,
	input logic [31:0] pc,
	input logic bdIn,
	input logic exlClr,
	output logic [31:0] rdData,
	output logic excRequest,
	output logic [31:0] epc
);

	// SR fields
	logic [5:0] im;
	logic exl;
	logic ie;

	// Cause fields
	logic bd;
	logic [5:0] ip;
	logic [4:0] causeCode;

	// Full registers
	logic [31:0] epcReg;
	logic [31:0] prId;

	// Decision
	logic intReq;
	logic excReq;

	// Return address
	logic [31:0] pcAligned;
	logic [31:0] epcNext;

	// Read words
	logic [31:0] srWord;
	logic [31:0] causeWord;

	//////////////////////////////////////////////////
	// Interrupt and exception decision
	//////////////////////////////////////////////////

	// Masked hardware lines, global enable, not already in handler
	assign intReq = (|(hwInt & im)) & ie & ~exl;
	// Any encoded exception outside the handler
	assign excReq = (excCode != cp0Pkg::codeInt) & ~exl;
	assign excRequest = intReq | excReq;

	// Delay slot instruction returns to its branch
	assign pcAligned = {pc[31:2], 2'b00};
	assign epcNext = bdIn ? pcAligned - 32'd4 : pcAligned;

	assign epc = epcReg;

	//////////////////////////////////////////////////
	// Register read
	//////////////////////////////////////////////////

	always_comb begin
		srWord = '0;
		srWord[cp0Pkg::srImHi:cp0Pkg::srImLo] = im;
		srWord[cp0Pkg::srExlBit] = exl;
		srWord[cp0Pkg::srIeBit] = ie;
	end

	always_comb begin
		causeWord = '0;
		causeWord[cp0Pkg::causeBdBit] = bd;
		causeWord[cp0Pkg::causeIpHi:cp0Pkg::causeIpLo] = ip;
		causeWord[cp0Pkg::causeCodeHi:cp0Pkg::causeCodeLo] = causeCode;
	end

	// mfc0 path
	always_comb begin
		case (cp0Bus.rdAddr)
			cp0Pkg::regSr: rdData = srWord;
			cp0Pkg::regCause: rdData = causeWord;
			cp0Pkg::regEpc: rdData = epcReg;
			cp0Pkg::regPrid: rdData = prId;
			// Unimplemented registers
			default: rdData = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Register update
	//////////////////////////////////////////////////

	// Later assignments win, so the order below is the write priority
	always_ff @(posedge clk) begin
		if (reset) begin
			im <= '0;
			exl <= 1'b0;
			ie <= 1'b0;
			bd <= 1'b0;
			ip <= '0;
			causeCode <= cp0Pkg::codeInt;
			epcReg <= '0;
			prId <= cp0Pkg::prIdReset;
		end
		else begin
			// Pending lines follow the inputs every cycle
			ip <= hwInt;

			// mtc0 has the lowest priority
			if (cp0Bus.we) begin
				case (cp0Bus.wrAddr)
					cp0Pkg::regSr: begin
						im <= cp0Bus.wrData[cp0Pkg::srImHi:cp0Pkg::srImLo];
						exl <= cp0Bus.wrData[cp0Pkg::srExlBit];
						ie <= cp0Bus.wrData[cp0Pkg::srIeBit];
					end
					cp0Pkg::regCause: begin
						bd <= cp0Bus.wrData[cp0Pkg::causeBdBit];
						causeCode <= cp0Bus.wrData[cp0Pkg::causeCodeHi:cp0Pkg::causeCodeLo];
					end
					cp0Pkg::regEpc: epcReg <= {cp0Bus.wrData[31:2], 2'b00};
					cp0Pkg::regPrid: prId <= cp0Bus.wrData;
					default: ;
				endcase
			end

			// Exception entry
			if (excRequest) begin
				exl <= 1'b1;
				epcReg <= epcNext;
				bd <= bdIn;
				// Interrupt wins when both are pending
				causeCode <= intReq ? cp0Pkg::codeInt : excCode;
			end

			// eret beats everything
			if (exlClr) begin
				exl <= 1'b0;
				bd <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Handler entry always masks the next request
	assert property (@(posedge clk) disable iff (reset)
		excRequest && !exlClr |=> exl);

	// EPC stays word aligned whatever its source
	assert property (@(posedge clk) disable iff (reset)
		epcReg[1:0] == 2'b00);

endmodule

// File: verilog/excEncoder.sv
`timescale 1ns/100ps

module excEncoder (
	input cp0Pkg::excFlags_t flags,
	output logic [4:0] excCode
);

	//////////////////////////////////////////////////
	// Fixed priority encode
	//////////////////////////////////////////////////

	// Order matches the field order of excFlags_t
	always_comb begin
		if (flags.fetchAdEL) begin
			// Bad fetch address beats anything decoded from that word
			excCode = cp0Pkg::codeAdEL;
		end
		else if (flags.ri) begin
			excCode = cp0Pkg::codeRi;
		end
		else if (flags.sys) begin
			excCode = cp0Pkg::codeSys;
		end
		else if (flags.ov) begin
			// Arithmetic overflow from execute
			excCode = cp0Pkg::codeOv;
		end
		else if (flags.loadAdEL) begin
			// Misaligned data load
			excCode = cp0Pkg::codeAdEL;
		end
		else if (flags.storeAdES) begin
			// Misaligned data store
			excCode = cp0Pkg::codeAdES;
		end
		else begin
			// No exception, codeInt doubles as none
			excCode = cp0Pkg::codeInt;
		end

		// Nonzero code exactly when some flag is set
		assert ((excCode != cp0Pkg::codeInt) == (|flags))
			else $error("excEncoder code %h does not match flags %b", excCode, flags);
	end

endmodule

// File: verilog/excUnit.sv
`timescale 1ns/100ps

module excUnit (
	input logic clk,
	input logic reset,
	input cp0Pkg::cp0Access_t cp0Bus,
	output logic [31:0] cp0RdData,
	input cp0Pkg::timerAccess_t timerBus,
	output logic [31:0] timerRdData,
	input logic [31:0] pc,
	input logic bdIn,
	input cp0Pkg::excFlags_t flags,
	input logic exlClr,
	input logic [4:0] extInt,
	output logic excRequest,
	output logic [31:0] epc
);

	logic [4:0] excCode;
	logic timerIrq;
	logic [5:0] hwInt;

	//////////////////////////////////////////////////
	// Interrupt lines
	//////////////////////////////////////////////////

	// Timer sits on the lowest line, external devices above it
	assign hwInt[cp0Pkg::hwIntTimer] = timerIrq;
	assign hwInt[5:1] = extInt;

	//////////////////////////////////////////////////
	// Blocks
	//////////////////////////////////////////////////

	excEncoder encoder (
		.flags(flags),
		.excCode(excCode)
	);

	cp0Regs cp0 (
		.clk(clk),
		.reset(reset),
		.cp0Bus(cp0Bus),
		.excCode(excCode),
		.hwInt(hwInt),
		.pc(pc),
		.bdIn(bdIn),
		.exlClr(exlClr),
		.rdData(cp0RdData),
		.excRequest(excRequest),
		.epc(epc)
	);

	irqTimer timer (
		.clk(clk),
		.reset(reset),
		.bus(timerBus),
		.rdData(timerRdData),
		.irq(timerIrq)
	);

endmodule

// File: verilog/irqTimer.sv
`timescale 1ns/100ps

module irqTimer (
	input logic clk,
	input logic reset,
	input cp0Pkg::timerAccess_t bus,
	output logic [31:0] rdData,
	output logic irq
);

	// Control fields
	logic en;
	logic mode;
	logic irqEn;

	logic [31:0] preset;
	logic [31:0] count;
	logic [31:0] ctrlWord;
	logic countZero;

	assign countZero = (count == '0);

	// Level while expired and enabled
	assign irq = countZero & en & irqEn;

	//////////////////////////////////////////////////
	// Read
	//////////////////////////////////////////////////

	always_comb begin
		ctrlWord = '0;
		ctrlWord[cp0Pkg::timerCtrlEnBit] = en;
		ctrlWord[cp0Pkg::timerCtrlModeBit] = mode;
		ctrlWord[cp0Pkg::timerCtrlIrqEnBit] = irqEn;
	end

	always_comb begin
		case (bus.addr)
			cp0Pkg::timerAddrCtrl: rdData = ctrlWord;
			cp0Pkg::timerAddrPreset: rdData = preset;
			cp0Pkg::timerAddrCount: rdData = count;
			default: rdData = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Control and count
	//////////////////////////////////////////////////

	// Reload value for the count
	always_ff @(posedge clk) begin
		if (bus.we && bus.addr == cp0Pkg::timerAddrPreset) begin
			preset <= bus.wrData;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			en <= 1'b0;
			mode <= 1'b0;
			irqEn <= 1'b0;
			count <= '0;
		end
		else if (bus.we && bus.addr == cp0Pkg::timerAddrCtrl) begin
			en <= bus.wrData[cp0Pkg::timerCtrlEnBit];
			mode <= bus.wrData[cp0Pkg::timerCtrlModeBit];
			irqEn <= bus.wrData[cp0Pkg::timerCtrlIrqEnBit];
			// Starting the timer loads the count
			if (bus.wrData[cp0Pkg::timerCtrlEnBit]) begin
				count <= preset;
			end
		end
		else if (bus.we && bus.addr == cp0Pkg::timerAddrCount) begin
			count <= bus.wrData;
		end
		else if (en && !countZero) begin
			count <= count - 32'd1;
		end
		else if (en && mode) begin
			// Periodic reload keeps zero to one cycle
			count <= preset;
		end
	end

endmodule
